// File: source/stm_consts.svh
`ifndef STM_CONSTS_SVH
`define STM_CONSTS_SVH

// two sample banks
`define STM_NUM_SEGMENT 2

// sync, tic and sample index width
`define STM_IDX_W 16

// 256 samples per segment
`define STM_DEPTH_W 8

`define STM_DATA_W 32

// rep value that loops forever
`define STM_REP_INFINITE 32'hffff_ffff

// credits granted by the consumer at reset
`define STM_CREDITS 4

`endif

// File: source/stm_pkg.sv
package stm_pkg;

  // how a requested segment change starts
  typedef enum logic [7:0] {
    sync_idx = 8'h00,
    sys_time = 8'h01,
    gpio     = 8'h02,
    ext      = 8'hf0
  } stm_transition_mode_e;

  typedef enum logic [1:0] {
    wait_start    = 2'd0,
    finite_loop   = 2'd1,
    infinite_loop = 2'd2
  } stm_swap_state_e;

  // output index follows the timer or the tic counter
  typedef enum logic {
    idx_sync = 1'b0,
    idx_tic  = 1'b1
  } stm_idx_mode_e;

endpackage

// File: source/stm_settings_if.sv
`include "stm_consts.svh"

interface stm_settings_if;
  import stm_pkg::*;

  logic                  update;  // one cycle pulse
  logic                  req_segment;
  stm_transition_mode_e  transition_mode;
  logic [63:0]           transition_value;  // target time or gpio number
  logic [`STM_IDX_W-1:0] cycle [`STM_NUM_SEGMENT];
  logic [`STM_IDX_W-1:0] freq_div [`STM_NUM_SEGMENT];
  logic [31:0]           rep [`STM_NUM_SEGMENT];

  modport source (
    output update, req_segment, transition_mode, transition_value, cycle, freq_div, rep
  );

  modport timer (input cycle, freq_div);

  modport swap (
    input update, req_segment, transition_mode, transition_value, cycle, rep
  );

endinterface

// File: source/stm_timer.sv
`include "stm_consts.svh"

module stm_timer (
  input  logic                  CLK,
  input  logic                  rst,
  stm_settings_if.timer         settings,
  output logic [`STM_IDX_W-1:0] sync_idx [`STM_NUM_SEGMENT]
);

  for (genvar i = 0; i < `STM_NUM_SEGMENT; i++) begin : gen_seg
    logic [`STM_IDX_W-1:0] presc;
    logic [`STM_IDX_W-1:0] idx_q;
    logic                  tick;

    // freq_div of 0 behaves like 1
    assign tick = ({1'b0, presc} + 1'b1) >= {1'b0, settings.freq_div[i]};

    always_ff @(posedge CLK) begin
      if (rst) begin
        presc <= '0;
        idx_q <= '0;
      end else if (tick) begin
        presc <= '0;
        if (idx_q >= settings.cycle[i]) begin  // wrap after last index
          idx_q <= '0;
        end else begin
          idx_q <= idx_q + 1'b1;
        end
      end else begin
        presc <= presc + 1'b1;
      end
    end

    assign sync_idx[i] = idx_q;
  end

endmodule

// File: source/stm_swapchain.sv
`include "stm_consts.svh"

module stm_swapchain (
  input  logic                  CLK,
  input  logic                  rst,
  stm_settings_if.swap          settings,
  input  logic [63:0]           sys_time,
  input  logic [3:0]            gpio_in,
  input  logic [`STM_IDX_W-1:0] sync_idx [`STM_NUM_SEGMENT],
  output logic                  segment,
  output logic                  stop,
  output logic [`STM_IDX_W-1:0] idx [`STM_NUM_SEGMENT]
);
  import stm_pkg::*;

  stm_swap_state_e       state;
  stm_idx_mode_e         idx_mode;
  logic                  ext_mode;
  logic                  req_seg_q;
  logic [31:0]           rep_q;
  logic [31:0]           loop_cnt;
  logic [64:0]           time_diff;  // bit 64 set once sys_time is past target
  logic [`STM_IDX_W-1:0] idx_old [`STM_NUM_SEGMENT];
  logic [`STM_IDX_W-1:0] tic_idx [`STM_NUM_SEGMENT];
  logic                  idx_changed [`STM_NUM_SEGMENT];
  logic [1:0]            gpio_sel;
  logic                  start;
  logic                  start_tic;
  logic                  act_changed;
  logic                  act_wrap;
  logic                  tic_last;
  logic                  pass_end;
  logic                  loop_done;

  always_ff @(posedge CLK) begin
    if (rst) begin
      time_diff <= '0;
    end else begin
      time_diff <= {1'b0, settings.transition_value} - {1'b0, sys_time};
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int i = 0; i < `STM_NUM_SEGMENT; i++) begin
        idx_old[i] <= '0;
      end
    end else begin
      idx_old <= sync_idx;
    end
  end

  for (genvar i = 0; i < `STM_NUM_SEGMENT; i++) begin : gen_idx
    assign idx_changed[i] = idx_old[i] != sync_idx[i];
    assign idx[i] = (idx_mode == idx_sync) ? idx_old[i] : tic_idx[i];
  end

  assign gpio_sel    = settings.transition_value[1:0];
  assign act_changed = idx_changed[segment];
  assign act_wrap    = act_changed && (sync_idx[segment] == '0);
  assign tic_last    = tic_idx[segment] == settings.cycle[segment];
  assign loop_done   = loop_cnt == rep_q;

  // one pass ends on a timer wrap, or when the tic counter rolls over
  assign pass_end = (idx_mode == idx_sync) ? act_wrap : (act_changed && tic_last);

  // trigger for the pending transition
  always_comb begin
    start     = 1'b0;
    start_tic = 1'b0;
    case (settings.transition_mode)
      stm_pkg::sync_idx: begin
        start = idx_changed[req_seg_q] && (sync_idx[req_seg_q] == '0);
      end
      stm_pkg::sys_time: begin
        start     = time_diff[64];
        start_tic = 1'b1;
      end
      stm_pkg::gpio: begin
        start     = idx_changed[req_seg_q] && gpio_in[gpio_sel];
        start_tic = 1'b1;
      end
      default: ;  // ext never waits
    endcase
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      segment   <= 1'b0;
      stop      <= 1'b0;
      state     <= infinite_loop;
      idx_mode  <= idx_sync;
      ext_mode  <= 1'b0;
      req_seg_q <= 1'b0;
      rep_q     <= '0;
      loop_cnt  <= '0;
      for (int i = 0; i < `STM_NUM_SEGMENT; i++) begin
        tic_idx[i] <= '0;
      end
    end else if (settings.update) begin
      if ((settings.req_segment == segment) ||
          (settings.rep[settings.req_segment] == `STM_REP_INFINITE)) begin
        // switch right away
        segment  <= settings.req_segment;
        stop     <= 1'b0;
        idx_mode <= idx_sync;
        ext_mode <= settings.transition_mode == stm_pkg::ext;
        state    <= infinite_loop;
      end else begin
        req_seg_q <= settings.req_segment;
        rep_q     <= settings.rep[settings.req_segment];
        state     <= wait_start;
      end
    end else begin
      case (state)
        wait_start: begin
          if (start) begin
            stop     <= 1'b0;
            loop_cnt <= '0;
            segment  <= req_seg_q;
            state    <= finite_loop;
            if (start_tic) begin
              idx_mode           <= idx_tic;
              tic_idx[req_seg_q] <= '0;
            end else begin
              idx_mode <= idx_sync;
            end
          end
        end
        infinite_loop: begin
          if (ext_mode && act_wrap) begin
            segment <= ~segment;  // ping-pong on every wrap
          end
        end
        finite_loop: begin
          if ((idx_mode == idx_tic) && act_changed) begin
            tic_idx[segment] <= tic_last ? '0 : tic_idx[segment] + 1'b1;
          end
          if (pass_end) begin
            if (loop_done) begin
              stop <= 1'b1;
            end else begin
              loop_cnt <= loop_cnt + 1'b1;
            end
          end
        end
        default: state <= infinite_loop;
      endcase
    end
  end

endmodule

// File: source/stm_sample_reader.sv
`include "stm_consts.svh"

module stm_sample_reader (
  input  logic                    CLK,
  input  logic                    rst,
  input  logic                    segment,
  input  logic [`STM_IDX_W-1:0]   idx,
  input  logic                    wr_en,
  input  logic                    wr_segment,
  input  logic [`STM_DEPTH_W-1:0] wr_addr,
  input  logic [`STM_DATA_W-1:0]  wr_data,
  input  logic                    credit_return,
  output logic                    sample_valid,
  output logic [`STM_DATA_W-1:0]  sample_data,
  output logic                    sample_segment,
  output logic [`STM_IDX_W-1:0]   sample_idx
);

  localparam int credit_w = $clog2(`STM_CREDITS + 1);

  logic [`STM_DATA_W-1:0] mem [`STM_NUM_SEGMENT * (2 ** `STM_DEPTH_W)];
  logic                   last_seg;
  logic [`STM_IDX_W-1:0]  last_idx;
  logic                   changed;
  logic                   pend_valid;
  logic                   pend_seg;
  logic [`STM_IDX_W-1:0]  pend_idx;
  logic [credit_w-1:0]    credit_cnt;
  logic                   send;

  assign changed = (segment != last_seg) || (idx != last_idx);
  assign send    = pend_valid && (credit_cnt != '0);  // never send without a credit

  always_ff @(posedge CLK) begin
    if (rst) begin
      last_seg       <= 1'b0;
      last_idx       <= '0;
      pend_valid     <= 1'b0;
      pend_seg       <= 1'b0;
      pend_idx       <= '0;
      sample_valid   <= 1'b0;
      sample_data    <= '0;
      sample_segment <= 1'b0;
      sample_idx     <= '0;
      credit_cnt     <= credit_w'(`STM_CREDITS);
    end else begin
      last_seg     <= segment;
      last_idx     <= idx;
      sample_valid <= send;
      if (changed) begin  // newest index wins, older unsent ones are dropped
        pend_valid <= 1'b1;
        pend_seg   <= segment;
        pend_idx   <= idx;
      end else if (send) begin
        pend_valid <= 1'b0;
      end
      if (send) begin
        sample_data    <= mem[{pend_seg, pend_idx[`STM_DEPTH_W-1:0]}];
        sample_segment <= pend_seg;
        sample_idx     <= pend_idx;
      end
      case ({credit_return, send})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[{wr_segment, wr_addr}] <= wr_data;
    end
  end

endmodule

// File: source/stm_top.sv
`include "stm_consts.svh"

module stm_top (
  input  logic                          CLK,
  input  logic                          rst,
  input  logic [63:0]                   sys_time,
  input  logic [3:0]                    gpio_in,
  input  logic                          update,
  input  logic                          req_segment,
  input  stm_pkg::stm_transition_mode_e transition_mode,
  input  logic [63:0]                   transition_value,
  input  logic [`STM_IDX_W-1:0]         cycle_0,
  input  logic [`STM_IDX_W-1:0]         cycle_1,
  input  logic [`STM_IDX_W-1:0]         freq_div_0,
  input  logic [`STM_IDX_W-1:0]         freq_div_1,
  input  logic [31:0]                   rep_0,
  input  logic [31:0]                   rep_1,
  input  logic                          wr_en,
  input  logic                          wr_segment,
  input  logic [`STM_DEPTH_W-1:0]       wr_addr,
  input  logic [`STM_DATA_W-1:0]        wr_data,
  input  logic                          credit_return,
  output logic                          segment,
  output logic                          stop,
  output logic                          sample_valid,
  output logic [`STM_DATA_W-1:0]        sample_data,
  output logic                          sample_segment,
  output logic [`STM_IDX_W-1:0]         sample_idx
);

  logic [`STM_IDX_W-1:0] sync_idx [`STM_NUM_SEGMENT];
  logic [`STM_IDX_W-1:0] seg_idx [`STM_NUM_SEGMENT];

  stm_settings_if settings_if ();

  assign settings_if.update           = update;
  assign settings_if.req_segment      = req_segment;
  assign settings_if.transition_mode  = transition_mode;
  assign settings_if.transition_value = transition_value;
  assign settings_if.cycle[0]         = cycle_0;
  assign settings_if.cycle[1]         = cycle_1;
  assign settings_if.freq_div[0]      = freq_div_0;
  assign settings_if.freq_div[1]      = freq_div_1;
  assign settings_if.rep[0]           = rep_0;
  assign settings_if.rep[1]           = rep_1;

  stm_timer u_timer (
    .CLK      (CLK),
    .rst      (rst),
    .settings (settings_if.timer),
    .sync_idx (sync_idx)
  );

  stm_swapchain u_swapchain (
    .CLK      (CLK),
    .rst      (rst),
    .settings (settings_if.swap),
    .sys_time (sys_time),
    .gpio_in  (gpio_in),
    .sync_idx (sync_idx),
    .segment  (segment),
    .stop     (stop),
    .idx      (seg_idx)
  );

  // only the playing segment's index reaches the reader
  stm_sample_reader u_reader (
    .CLK            (CLK),
    .rst            (rst),
    .segment        (segment),
    .idx            (seg_idx[segment]),
    .wr_en          (wr_en),
    .wr_segment     (wr_segment),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .credit_return  (credit_return),
    .sample_valid   (sample_valid),
    .sample_data    (sample_data),
    .sample_segment (sample_segment),
    .sample_idx     (sample_idx)
  );

endmodule

// File: dv/stm_assert.sv
`include "stm_consts.svh"

module stm_assert (
  input logic                          CLK,
  input logic                          rst,
  input logic                          update,
  input logic                          req_segment,
  input stm_pkg::stm_transition_mode_e transition_mode,
  input logic [63:0]                   transition_value,
  input logic [`STM_IDX_W-1:0]         cycle_0,
  input logic [`STM_IDX_W-1:0]         cycle_1,
  input logic [31:0]                   rep_0,
  input logic [31:0]                   rep_1,
  input logic [63:0]                   sys_time,
  input logic [3:0]                    gpio_in,
  input logic [`STM_IDX_W-1:0]         sync_idx [`STM_NUM_SEGMENT],
  input logic                          segment,
  input logic                          stop,
  input logic                          wr_en,
  input logic                          wr_segment,
  input logic [`STM_DEPTH_W-1:0]       wr_addr,
  input logic [`STM_DATA_W-1:0]        wr_data,
  input logic                          credit_return,
  input logic                          sample_valid,
  input logic [`STM_DATA_W-1:0]        sample_data,
  input logic                          sample_segment,
  input logic [`STM_IDX_W-1:0]         sample_idx
);
  timeunit 1ns;
  timeprecision 1ps;
  import stm_pkg::*;

  int                     fail_cnt = 0;
  logic [`STM_DATA_W-1:0] shadow [`STM_NUM_SEGMENT * (2 ** `STM_DEPTH_W)];
  logic                   wr_en_q;
  logic [`STM_DEPTH_W:0]  wr_ptr_q;  // {segment, addr}
  logic [`STM_DATA_W-1:0] wr_data_q;
  logic [`STM_IDX_W-1:0]  prev_sync [`STM_NUM_SEGMENT];
  logic [`STM_IDX_W-1:0]  cyc [`STM_NUM_SEGMENT];
  logic [63:0]            sys_time_q;
  logic [31:0]            rep_req;
  logic [31:0]            pend_rep;
  logic [31:0]            passes;
  logic [`STM_IDX_W-1:0]  tic;
  logic [`STM_IDX_W-1:0]  exp_idx;
  logic                   play_seg_q;
  logic                   play_seg_qq;
  logic [`STM_IDX_W-1:0]  play_idx_q;
  logic [`STM_IDX_W-1:0]  play_idx_qq;
  logic                   exp_seg;
  logic                   exp_stop;
  logic                   pend;
  logic                   pend_seg;
  logic                   run;
  logic                   tic_mode;
  logic                   ext_on;
  logic                   pend_chg;
  logic                   act_chg;
  logic                   act_wrap;
  logic                   pass_end;
  logic                   trig;
  int                     out_cnt;

  assign cyc[0]   = cycle_0;
  assign cyc[1]   = cycle_1;
  assign rep_req  = req_segment ? rep_1 : rep_0;
  assign pend_chg = sync_idx[pend_seg] != prev_sync[pend_seg];
  assign act_chg  = sync_idx[exp_seg] != prev_sync[exp_seg];
  assign act_wrap = act_chg && (sync_idx[exp_seg] == '0);
  assign pass_end = tic_mode ? (act_chg && (tic == cyc[exp_seg])) : act_wrap;

  // index handed to the reader
  assign exp_idx = tic_mode ? tic : prev_sync[exp_seg];

  always_comb begin
    case (transition_mode)
      stm_pkg::sync_idx: trig = pend_chg && (sync_idx[pend_seg] == '0);
      stm_pkg::sys_time: trig = sys_time_q > transition_value;  // time already passed
      stm_pkg::gpio:     trig = pend_chg && gpio_in[transition_value[1:0]];
      default:           trig = 1'b0;
    endcase
  end

  // shadow lags one cycle, same as a read racing a write
  always_ff @(posedge CLK) begin
    wr_en_q   <= wr_en;
    wr_ptr_q  <= {wr_segment, wr_addr};
    wr_data_q <= wr_data;
    if (wr_en_q) begin
      shadow[wr_ptr_q] <= wr_data_q;
    end
  end

  // reference model of segment and stop
  always_ff @(posedge CLK) begin
    prev_sync   <= sync_idx;
    sys_time_q  <= sys_time;
    play_seg_q  <= exp_seg;  // reader latches, then sends a cycle later
    play_idx_q  <= exp_idx;
    play_seg_qq <= play_seg_q;
    play_idx_qq <= play_idx_q;
    if (rst) begin
      exp_seg  <= 1'b0;
      exp_stop <= 1'b0;
      pend     <= 1'b0;
      run      <= 1'b0;
      ext_on   <= 1'b0;
      tic_mode <= 1'b0;
      out_cnt  <= 0;
    end else begin
      out_cnt <= out_cnt + int'(sample_valid) - int'(credit_return);
      if (update) begin
        run <= 1'b0;
        if ((req_segment == exp_seg) || (rep_req == `STM_REP_INFINITE)) begin
          exp_seg  <= req_segment;
          exp_stop <= 1'b0;
          pend     <= 1'b0;
          tic_mode <= 1'b0;
          ext_on   <= transition_mode == stm_pkg::ext;
        end else begin
          pend     <= 1'b1;
          pend_seg <= req_segment;
          pend_rep <= rep_req;
        end
      end else if (pend) begin
        if (trig) begin
          exp_seg  <= pend_seg;
          exp_stop <= 1'b0;
          pend     <= 1'b0;
          run      <= 1'b1;
          passes   <= '0;
          tic      <= '0;
          tic_mode <= transition_mode != stm_pkg::sync_idx;
        end
      end else if (run) begin
        if (tic_mode && act_chg) begin
          tic <= (tic == cyc[exp_seg]) ? '0 : tic + 1'b1;
        end
        if (pass_end) begin
          if (passes == pend_rep) begin
            exp_stop <= 1'b1;  // rep+1 passes done
          end else begin
            passes <= passes + 1'b1;
          end
        end
      end else if (ext_on && act_wrap) begin
        exp_seg <= ~exp_seg;
      end
    end
  end

  a_segment: assert property (@(posedge CLK) disable iff (rst) segment == exp_seg)
    else begin
      $error("** Error %0t segment %0d expected %0d", $time, $sampled(segment), exp_seg);
      fail_cnt++;
    end

  a_stop: assert property (@(posedge CLK) disable iff (rst) stop == exp_stop)
    else begin
      $error("** Error %0t stop %0d expected %0d", $time, $sampled(stop), exp_stop);
      fail_cnt++;
    end

  a_sample_data: assert property (@(posedge CLK) disable iff (rst)
      sample_valid |-> sample_data === shadow[{sample_segment, sample_idx[`STM_DEPTH_W-1:0]}])
    else begin
      $error("** Error %0t sample_data %h expected %h", $time, $sampled(sample_data),
             shadow[{$sampled(sample_segment), $sampled(sample_idx[`STM_DEPTH_W-1:0])}]);
      fail_cnt++;
    end

  // newest played index at send time
  a_sample_index: assert property (@(posedge CLK) disable iff (rst)
      sample_valid |-> (sample_segment == play_seg_qq) && (sample_idx == play_idx_qq))
    else begin
      $error("** Error %0t sample_segment,sample_idx %0d,%0d expected %0d,%0d", $time,
             $sampled(sample_segment), $sampled(sample_idx), play_seg_qq, play_idx_qq);
      fail_cnt++;
    end

  a_credit_bound: assert property (@(posedge CLK) disable iff (rst)
      out_cnt + int'(sample_valid) <= `STM_CREDITS)
    else begin
      $error("** Error %0t outstanding sends %0d expected at most %0d", $time,
             out_cnt + int'($sampled(sample_valid)), `STM_CREDITS);
      fail_cnt++;
    end

endmodule

bind stm_top stm_assert u_assert (.*);

// File: dv/stm_tb.sv
`include "stm_consts.svh"

module stm_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import stm_pkg::*;

  localparam int period = 100;
  localparam int skew   = 1;
  // reset, fill, update tests, gpio, ext, credit stall
  localparam int test_cycles = 16 + 20 + 25 + 100 + 90 + 90 + 110 + 80;

  logic                  CLK = 1'b0;
  logic                  rst;
  logic [63:0]           sys_time;
  logic [3:0]            gpio_in;
  logic                  update;
  logic                  req_segment;
  stm_transition_mode_e  transition_mode;
  logic [63:0]           transition_value;
  logic [`STM_IDX_W-1:0] cycle_0;
  logic [`STM_IDX_W-1:0] cycle_1;
  logic [`STM_IDX_W-1:0] freq_div_0;
  logic [`STM_IDX_W-1:0] freq_div_1;
  logic [31:0]           rep_0;
  logic [31:0]           rep_1;
  logic                  wr_en;
  logic                  wr_segment;
  logic [`STM_DEPTH_W-1:0] wr_addr;
  logic [`STM_DATA_W-1:0] wr_data;
  logic                  credit_return;
  logic                  segment;
  logic                  stop;
  logic                  sample_valid;
  logic [`STM_DATA_W-1:0] sample_data;
  logic                  sample_segment;
  logic [`STM_IDX_W-1:0] sample_idx;
  logic [31:0]           lfsr = 32'hc06a_23ee;
  logic                  returns_on;
  int                    outstanding;

  stm_top DUT (.*);

  always #(period / 2) CLK = ~CLK;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      bits = {bits[30:0], lfsr[0]};
    end
  endtask

  task automatic next_cycle(input int n = 1);
    repeat (n) @(posedge CLK);
    #skew;
  endtask

  task automatic send_update(input logic seg, input stm_transition_mode_e mode,
                             input logic [63:0] value);
    req_segment      = seg;
    transition_mode  = mode;
    transition_value = value;
    update           = 1'b1;
    next_cycle();
    update = 1'b0;
  endtask

  task automatic wait_stop();
    while (stop) next_cycle();  // cleared when the new segment starts
    while (!stop) next_cycle();
  endtask

  task automatic wait_toggles(input int n);
    logic seg_q;
    repeat (n) begin
      seg_q = segment;
      while (segment == seg_q) next_cycle();
    end
  endtask

  task automatic fill_memory(input int words);
    logic [31:0] data;
    for (int s = 0; s < `STM_NUM_SEGMENT; s++) begin
      for (int a = 0; a < words; a++) begin
        take_bits(32, data);
        wr_en      = 1'b1;
        wr_segment = s[0];
        wr_addr    = a[`STM_DEPTH_W-1:0];
        wr_data    = data;
        next_cycle();
      end
    end
    wr_en = 1'b0;
  endtask

  // consumer hands credits back on random cycles
  always @(posedge CLK) begin
    logic [31:0] coin;
    if (rst) begin
      outstanding = 0;
    end else begin
      outstanding = outstanding + int'(sample_valid) - int'(credit_return);
    end
    #skew;
    credit_return = 1'b0;
    if (returns_on && outstanding > 0) begin
      take_bits(1, coin);
      credit_return = coin[0];
    end
  end

  always @(posedge CLK) begin
    #skew sys_time = sys_time + 1'b1;
  end

  always @(posedge CLK) begin
    if (DUT.u_assert.fail_cnt != 0) begin
      $display("Errors found");
      $fatal(1, "a DUT assertion failed");
    end
  end

  initial begin
    #(2 * test_cycles * period);
    $display("Errors found");
    $fatal(1, "watchdog expired before the tests finished");
  end

  initial begin
    rst              = 1'b1;
    sys_time         = '0;
    gpio_in          = '0;
    update           = 1'b0;
    req_segment      = 1'b0;
    transition_mode  = stm_pkg::sync_idx;
    transition_value = '0;
    cycle_0          = 16'd7;
    cycle_1          = 16'd5;
    freq_div_0       = 16'd3;  // short passes
    freq_div_1       = 16'd3;
    rep_0            = `STM_REP_INFINITE;
    rep_1            = `STM_REP_INFINITE;
    wr_en            = 1'b0;
    wr_segment       = 1'b0;
    wr_addr          = '0;
    wr_data          = '0;
    credit_return    = 1'b0;
    returns_on       = 1'b0;
    next_cycle(16);
    rst = 1'b0;
    fill_memory(8);
    returns_on = 1'b1;

    send_update(1'b1, stm_pkg::sync_idx, '0);  // immediate switch
    next_cycle(10);
    send_update(1'b1, stm_pkg::sync_idx, '0);  // same segment again
    next_cycle(10);

    rep_0 = 32'd2;
    send_update(1'b0, stm_pkg::sync_idx, '0);
    wait_stop();

    rep_1 = 32'd1;
    send_update(1'b1, stm_pkg::sys_time, sys_time + 64'd40);
    wait_stop();

    // gpio 2 held low first, no start allowed
    rep_0 = 32'd1;
    send_update(1'b0, stm_pkg::gpio, 64'd2);
    next_cycle(30);
    gpio_in[2] = 1'b1;
    wait_stop();
    gpio_in = '0;

    rep_1 = `STM_REP_INFINITE;
    send_update(1'b1, stm_pkg::ext, '0);
    wait_toggles(4);

    // starve the reader, then let it resume
    returns_on = 1'b0;
    next_cycle(40);
    returns_on = 1'b1;
    while (!sample_valid) next_cycle();
    next_cycle(20);

    if (DUT.u_assert.fail_cnt == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Errors found");
      $fatal(1, "%0d assertion failures", DUT.u_assert.fail_cnt);
    end
  end

endmodule

// File: build.f
+incdir+source
source/stm_pkg.sv
source/stm_settings_if.sv
source/stm_timer.sv
source/stm_swapchain.sv
source/stm_sample_reader.sv
source/stm_top.sv
dv/stm_assert.sv
dv/stm_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= stm_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= No errors

SOURCES := $(wildcard source/*.sv source/*.svh dv/*.sv)

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
